/* src/serial_params.svh */
`ifndef SERIAL_PARAMS_SVH
`define SERIAL_PARAMS_SVH

// ----------------------------------------
// Host command nibbles
// ----------------------------------------

`define SERIAL_CMD_READ         4'hA    // Register word back to host
`define SERIAL_CMD_WRITE        4'h5    // Four data bytes follow

// ----------------------------------------
// Register map
// ----------------------------------------

`define ADR_COMP_CONFIG         4'h1
`define ADR_PULSE_CTRL          4'h2
`define ADR_MUX_SEL             4'h4
`define ADR_HALFSTRIPS          4'h5    // Read-only, live
`define ADR_HALFSTRIPS_EXPECT   4'h6
`define ADR_HALFSTRIPS_ERRCNT   4'h7    // Read-only, live
`define ADR_ADC                 4'h8

// ----------------------------------------
// Word transfer
// ----------------------------------------

`define DWORD_BYTES             4       // LSB first on the wire
`define READ_FILLER             32'hDEAD_BEEF

// Power-up values, chip selects of the serial DACs and ADC idle high
`define PULSE_CTRL_RESET        32'h0000_0020   // pdac_en_n in bit 5
`define ADC_RESET               32'h0000_0001   // adc_cs_n in bit 0

`endif

/* src/serial_pkg.sv */
package serial_pkg;

    typedef logic [3:0] reg_adr_t;

    // Write request from the FIFO link to the register file
    typedef struct packed {
        logic        strobe;    // One cycle per completed word
        reg_adr_t    adr;
        logic [31:0] data;
    } host_write_t;

    // ----------------------------------------
    // Register layouts, MSB first
    // ----------------------------------------

    typedef struct packed {
        logic [22:0] spare;
        logic        cdac_sclk;     // Bit 8
        logic        cdac_din;
        logic        cdac_en_n;
        logic        lctrst;        // Bit 5
        logic [1:0]  pkmode;
        logic [2:0]  pktime;        // Bits 2:0
    } comp_config_t;

    typedef struct packed {
        logic [9:0]  spare;
        logic [1:0]  live_bits;     // Bits 21:20, status on readback
        logic        triad_persist1;
        logic [3:0]  triad_persist;
        logic        compout_expect;    // Bit 14
        logic [2:0]  bx_delay;
        logic        compin_inject;
        logic        compout_errcnt_rst;
        logic        halfstrips_errcnt_rst;  // Bit 8
        logic        pdac_sclk;
        logic        pdac_din;
        logic        pdac_en_n;     // Bit 5
        logic [3:0]  pulse_width;
        logic        fire_pulse;    // Bit 0
    } pulse_ctrl_t;

    typedef struct packed {
        logic [28:0] spare;         // Bit 3 carries adc_miso on readback
        logic        adc_sclk;
        logic        adc_mosi;
        logic        adc_cs_n;      // Bit 0
    } adc_ctrl_t;

    // One incoming data word, read by address
    typedef union packed {
        logic [31:0]  raw;
        comp_config_t comp;
        pulse_ctrl_t  pulse;
        adc_ctrl_t    adc;
    } reg_word_u;

    typedef struct packed {
        logic [15:0] mux_a1;        // Odd word bits
        logic [15:0] mux_a0;        // Even word bits
    } mux_sel_t;

    // ----------------------------------------
    // Stored registers and board inputs
    // ----------------------------------------

    typedef struct packed {
        comp_config_t comp;
        pulse_ctrl_t  pulse;
        logic [31:0]  mux_word;
        logic [31:0]  halfstrips_expect;
        adc_ctrl_t    adc;
    } ctrl_state_t;

    typedef struct packed {
        logic [31:0] halfstrips;
        logic [31:0] halfstrips_errcnt;
        logic        compout_last;
        logic        pulser_ready;
        logic        adc_miso;
    } board_status_t;

endpackage

/* src/ft245_link.sv */
`include "serial_params.svh"

module ft245_link
    import serial_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ft_rxf_n,       // Host byte waiting
    input  logic        ft_txe_n,       // Room to send
    input  logic [7:0]  ft_byte_out,
    output logic [7:0]  ft_byte_in,
    output logic        serial_rd_n,
    output logic        serial_wr_n,
    output reg_adr_t    rd_adr,
    input  logic [31:0] rd_data,
    output host_write_t host_write
);

    localparam int unsigned IDX_W = $clog2(`DWORD_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`DWORD_BYTES - 1);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_DECODE,
        ST_RECV,
        ST_SEND
    } link_state_t;

    link_state_t      state;
    reg_adr_t         adr_q;
    logic [3:0]       cmd_q;
    logic [IDX_W-1:0] byte_idx;
    logic [31:0]      dword;        // Shared by both directions
    logic             wr_strobe;
    logic             rx_take;
    logic             tx_give;

    // A strobe must be high before the next byte may move
    assign rx_take = !ft_rxf_n && serial_rd_n;
    assign tx_give = !ft_txe_n && serial_wr_n;

    // ----------------------------------------
    // Byte-level FSM
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= ST_IDLE;
            adr_q       <= '0;
            cmd_q       <= '0;
            byte_idx    <= '0;
            serial_rd_n <= 1'b1;
            serial_wr_n <= 1'b1;
            ft_byte_in  <= '0;
            wr_strobe   <= 1'b0;
        end
        else
        begin
            serial_rd_n <= 1'b1;    // Pulses last one cycle
            serial_wr_n <= 1'b1;
            wr_strobe   <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (rx_take)
                    begin
                        {adr_q, cmd_q} <= ft_byte_out;  // Address in upper nibble
                        serial_rd_n    <= 1'b0;
                        state          <= ST_DECODE;
                    end
                end

                // rd_adr is settled here, so rd_data is valid
                ST_DECODE:
                begin
                    byte_idx <= '0;
                    case (cmd_q)
                        `SERIAL_CMD_READ:  state <= ST_SEND;
                        `SERIAL_CMD_WRITE: state <= ST_RECV;
                        default:           state <= ST_IDLE;  // Unknown, dropped
                    endcase
                end

                ST_RECV:
                begin
                    if (rx_take)
                    begin
                        serial_rd_n <= 1'b0;
                        byte_idx    <= byte_idx + 1'b1;
                        if (byte_idx == IDX_LAST)
                        begin
                            wr_strobe <= 1'b1;
                            state     <= ST_IDLE;
                        end
                    end
                end

                ST_SEND:
                begin
                    if (tx_give)
                    begin
                        ft_byte_in  <= dword[{byte_idx, 3'b000} +: 8];
                        serial_wr_n <= 1'b0;
                        byte_idx    <= byte_idx + 1'b1;
                        if (byte_idx == IDX_LAST)
                            state <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Word register, latched once per read or filled byte by byte
    always_ff @(posedge clk)
    begin
        if (state == ST_DECODE && cmd_q == `SERIAL_CMD_READ)
            dword <= rd_data;   // Snapshot, live inputs cannot tear it
        else if (state == ST_RECV && rx_take)
            dword[{byte_idx, 3'b000} +: 8] <= ft_byte_out;
    end

    assign rd_adr     = adr_q;
    assign host_write = '{strobe: wr_strobe, adr: adr_q, data: dword};

    // FIFO chip shares one data bus, so the two strobes are exclusive
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(!serial_rd_n && !serial_wr_n))
        else $error("serial_rd_n and serial_wr_n low together");

endmodule

/* src/ctrl_regs.sv */
`include "serial_params.svh"

module ctrl_regs
    import serial_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  host_write_t  host_write,
    output ctrl_state_t  state,
    output comp_config_t comp_config,
    output pulse_ctrl_t  pulse_ctrl,
    output mux_sel_t     mux_sel,
    output adc_ctrl_t    adc_ctrl,
    output logic [31:0]  halfstrips_expect
);

    ctrl_state_t regs;
    reg_word_u   wr_word;

    // Same word seen through the layout of its target register
    assign wr_word = reg_word_u'(host_write.data);

    // ----------------------------------------
    // Register file
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            regs.comp              <= '0;
            regs.pulse             <= pulse_ctrl_t'(`PULSE_CTRL_RESET);
            regs.mux_word          <= '0;
            regs.halfstrips_expect <= '0;
            regs.adc               <= adc_ctrl_t'(`ADC_RESET);
        end
        else if (host_write.strobe)
        begin
            case (host_write.adr)
                `ADR_COMP_CONFIG:       regs.comp              <= wr_word.comp;
                `ADR_PULSE_CTRL:        regs.pulse             <= wr_word.pulse;
                `ADR_MUX_SEL:           regs.mux_word          <= wr_word.raw;
                `ADR_HALFSTRIPS_EXPECT: regs.halfstrips_expect <= wr_word.raw;
                `ADR_ADC:               regs.adc               <= wr_word.adc;
                default: ;  // Read-only or unmapped
            endcase
        end
    end

    // ----------------------------------------
    // Board control pins
    // ----------------------------------------

    // Mux pairs interleaved in the word, a0 on even bits
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            mux_sel.mux_a0[i] = regs.mux_word[2*i];
            mux_sel.mux_a1[i] = regs.mux_word[2*i+1];
        end
    end

    assign comp_config       = regs.comp;
    assign pulse_ctrl        = regs.pulse;
    assign adc_ctrl          = regs.adc;
    assign halfstrips_expect = regs.halfstrips_expect;
    assign state             = regs;

    // Link completes one word per strobe
    strobe_single: assert property (@(posedge clk) disable iff (reset)
        host_write.strobe |=> !host_write.strobe)
        else $error("host_write.strobe held for two cycles");

endmodule

/* src/readback_mux.sv */
`include "serial_params.svh"

module readback_mux
    import serial_pkg::*;
(
    input  reg_adr_t      rd_adr,
    input  ctrl_state_t   state,
    input  board_status_t status,
    output logic [31:0]   rd_data
);

    pulse_ctrl_t pulse_rd;
    logic [31:0] adc_rd;

    // ----------------------------------------
    // Read word by address
    // ----------------------------------------

    always_comb
    begin
        pulse_rd           = state.pulse;
        pulse_rd.live_bits = {status.pulser_ready, status.compout_last};  // Bits 21, 20

        adc_rd    = state.adc;
        adc_rd[3] = status.adc_miso;   // Read-only data line

        case (rd_adr)
            `ADR_COMP_CONFIG:       rd_data = state.comp;
            `ADR_PULSE_CTRL:        rd_data = pulse_rd;
            `ADR_MUX_SEL:           rd_data = state.mux_word;   // Raw, not split
            `ADR_HALFSTRIPS:        rd_data = status.halfstrips;
            `ADR_HALFSTRIPS_EXPECT: rd_data = state.halfstrips_expect;
            `ADR_HALFSTRIPS_ERRCNT: rd_data = status.halfstrips_errcnt;
            `ADR_ADC:               rd_data = adc_rd;
            default:                rd_data = `READ_FILLER;
        endcase
    end

endmodule

/* src/serial_top.sv */
module serial_top
    import serial_pkg::*;
(
    input  logic          clk,
    input  logic          reset,

    // FT245 FIFO side
    input  logic          ft_rxf_n,
    input  logic          ft_txe_n,
    input  logic [7:0]    ft_byte_out,
    output logic [7:0]    ft_byte_in,
    output logic          serial_rd_n,
    output logic          serial_wr_n,

    // Board side
    input  board_status_t status,
    output comp_config_t  comp_config,
    output pulse_ctrl_t   pulse_ctrl,
    output mux_sel_t      mux_sel,
    output adc_ctrl_t     adc_ctrl,
    output logic [31:0]   halfstrips_expect
);

    host_write_t host_write;
    reg_adr_t    rd_adr;
    logic [31:0] rd_data;
    ctrl_state_t ctrl_state;

    // ----------------------------------------
    // Byte link, registers, readback
    // ----------------------------------------

    ft245_link u_link (
        .clk         (clk),
        .reset       (reset),
        .ft_rxf_n    (ft_rxf_n),
        .ft_txe_n    (ft_txe_n),
        .ft_byte_out (ft_byte_out),
        .ft_byte_in  (ft_byte_in),
        .serial_rd_n (serial_rd_n),
        .serial_wr_n (serial_wr_n),
        .rd_adr      (rd_adr),
        .rd_data     (rd_data),
        .host_write  (host_write)
    );

    ctrl_regs u_regs (
        .clk               (clk),
        .reset             (reset),
        .host_write        (host_write),
        .state             (ctrl_state),
        .comp_config       (comp_config),
        .pulse_ctrl        (pulse_ctrl),
        .mux_sel           (mux_sel),
        .adc_ctrl          (adc_ctrl),
        .halfstrips_expect (halfstrips_expect)
    );

    readback_mux u_readback (
        .rd_adr  (rd_adr),
        .state   (ctrl_state),
        .status  (status),
        .rd_data (rd_data)
    );

endmodule

/* bench/ft_host_tasks.svh */
`ifndef FT_HOST_TASKS_SVH
`define FT_HOST_TASKS_SVH

// ----------------------------------------
// Host side of the FT245 FIFO chip
// ----------------------------------------

localparam int STROBE_TIMEOUT = 20;     // Cycles per byte

// Random stall with the FIFO flag left high
task automatic stall_cycles();
    int n;
    n = bp_on ? int'($urandom % 4) : 0;
    if (n > 0)
    begin
        repeat (n) @(posedge clk);
        #1;
    end
endtask

task automatic send_byte(input logic [7:0] b);
    int waited;
    stall_cycles();
    ft_byte_out = b;
    ft_rxf_n    = 1'b0;
    exp_rd++;
    waited = 0;
    @(posedge clk);
    #1;
    while (serial_rd_n && waited < STROBE_TIMEOUT)
    begin
        @(posedge clk);
        #1;
        waited++;
    end
    ft_rxf_n = 1'b1;    // Still inside the serial_rd_n low cycle
    if (serial_rd_n)
    begin
        other_errs++;
        $display("Timeout at %0t: byte %h was never taken by the DUT", $time, b);
        end_run();
    end
endtask

task automatic receive_byte(output logic [7:0] b);
    int waited;
    stall_cycles();
    ft_txe_n = 1'b0;
    exp_wr++;
    waited = 0;
    @(posedge clk);
    #1;
    while (serial_wr_n && waited < STROBE_TIMEOUT)
    begin
        @(posedge clk);
        #1;
        waited++;
    end
    b        = ft_byte_in;  // Valid while serial_wr_n is low
    ft_txe_n = 1'b1;
    if (serial_wr_n)
    begin
        other_errs++;
        $display("Timeout at %0t: the DUT sent no byte back", $time);
        end_run();
    end
endtask

`endif

/* bench/serial_tb.sv */
`include "serial_params.svh"

module serial_tb
    import serial_pkg::*;
();

    logic          clk;
    logic          reset;
    logic          ft_rxf_n;
    logic          ft_txe_n;
    logic [7:0]    ft_byte_out;
    logic [7:0]    ft_byte_in;
    logic          serial_rd_n;
    logic          serial_wr_n;
    board_status_t status;
    comp_config_t  comp_config;
    pulse_ctrl_t   pulse_ctrl;
    mux_sel_t      mux_sel;
    adc_ctrl_t     adc_ctrl;
    logic [31:0]   halfstrips_expect;

    // Reference registers and check strobes
    logic [31:0] exp_comp, exp_pulse, exp_mux, exp_expect, exp_adc;
    logic [31:0] got_word, exp_word;
    logic        chk_read, chk_out, chk_count, chk_idle;
    logic        bp_on;
    int          rd_pulses, wr_pulses, exp_rd, exp_wr;
    int          mismatch_errs = 0;
    int          other_errs = 0;

    serial_top uut (
        .clk               (clk),
        .reset             (reset),
        .ft_rxf_n          (ft_rxf_n),
        .ft_txe_n          (ft_txe_n),
        .ft_byte_out       (ft_byte_out),
        .ft_byte_in        (ft_byte_in),
        .serial_rd_n       (serial_rd_n),
        .serial_wr_n       (serial_wr_n),
        .status            (status),
        .comp_config       (comp_config),
        .pulse_ctrl        (pulse_ctrl),
        .mux_sel           (mux_sel),
        .adc_ctrl          (adc_ctrl),
        .halfstrips_expect (halfstrips_expect)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (reset)
        begin
            rd_pulses <= 0;
            wr_pulses <= 0;
        end
        else
        begin
            if (!serial_rd_n) rd_pulses <= rd_pulses + 1;   // Each pulse is one cycle
            if (!serial_wr_n) wr_pulses <= wr_pulses + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatch_errs++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic end_run();
        $display("Error counts: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    `include "ft_host_tasks.svh"

    // ----------------------------------------
    // Reference model of the register map
    // ----------------------------------------

    function automatic logic [15:0] bits_at(input logic [31:0] w, input int first);
        logic [15:0] r;
        for (int i = 0; i < 16; i++)
            r[i] = w[2*i+first];
        return r;
    endfunction

    function automatic logic [31:0] expected_read(input logic [3:0] adr);
        logic [31:0] w;
        case (adr)
            `ADR_COMP_CONFIG:       w = exp_comp;
            `ADR_PULSE_CTRL:
            begin
                w     = exp_pulse;
                w[20] = status.compout_last;
                w[21] = status.pulser_ready;
            end
            `ADR_MUX_SEL:           w = exp_mux;
            `ADR_HALFSTRIPS:        w = status.halfstrips;
            `ADR_HALFSTRIPS_EXPECT: w = exp_expect;
            `ADR_HALFSTRIPS_ERRCNT: w = status.halfstrips_errcnt;
            `ADR_ADC:
            begin
                w    = exp_adc;
                w[3] = status.adc_miso;
            end
            default:                w = `READ_FILLER;
        endcase
        return w;
    endfunction

    function automatic logic [3:0] writable_adr(input int unsigned k);
        case (k)
            0:       return `ADR_COMP_CONFIG;
            1:       return `ADR_PULSE_CTRL;
            2:       return `ADR_MUX_SEL;
            3:       return `ADR_HALFSTRIPS_EXPECT;
            default: return `ADR_ADC;
        endcase
    endfunction

    // Give the write time to land, then raise the checks for one cycle
    task automatic settle_and_check(input logic with_read);
        repeat (2) @(posedge clk);
        #1;
        chk_out   = 1'b1;
        chk_count = 1'b1;
        chk_read  = with_read;
        @(posedge clk);
        #1;
        chk_out   = 1'b0;
        chk_count = 1'b0;
        chk_read  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
        send_byte({adr, `SERIAL_CMD_WRITE});
        for (int i = 0; i < `DWORD_BYTES; i++)
            send_byte(data[8*i +: 8]);     // LSB first
        case (adr)
            `ADR_COMP_CONFIG:       exp_comp   = data;
            `ADR_PULSE_CTRL:        exp_pulse  = data;
            `ADR_MUX_SEL:           exp_mux    = data;
            `ADR_HALFSTRIPS_EXPECT: exp_expect = data;
            `ADR_ADC:               exp_adc    = data;
            default: ;
        endcase
        settle_and_check(1'b0);
    endtask

    task automatic read_reg(input logic [3:0] adr);
        logic [7:0] b;
        send_byte({adr, `SERIAL_CMD_READ});
        for (int i = 0; i < `DWORD_BYTES; i++)
        begin
            receive_byte(b);
            got_word[8*i +: 8] = b;
        end
        exp_word = expected_read(adr);
        settle_and_check(1'b1);
    endtask

    task automatic randomize_status();
        status.halfstrips        = $urandom;
        status.halfstrips_errcnt = $urandom;
        status.compout_last      = 1'($urandom);
        status.pulser_ready      = 1'($urandom);
        status.adc_miso          = 1'($urandom);
    endtask

    // ----------------------------------------
    // Checking assertions
    // ----------------------------------------

    read_word_ok: assert property (@(posedge clk) disable iff (reset)
        chk_read |-> got_word == exp_word)
        else report_mismatch("read word", got_word, exp_word);

    comp_ok: assert property (@(posedge clk) disable iff (reset)
        chk_out |-> 32'(comp_config) == exp_comp)
        else report_mismatch("comp_config", 32'(comp_config), exp_comp);

    pulse_ok: assert property (@(posedge clk) disable iff (reset)
        chk_out |-> 32'(pulse_ctrl) == exp_pulse)
        else report_mismatch("pulse_ctrl", 32'(pulse_ctrl), exp_pulse);

    mux_ok: assert property (@(posedge clk) disable iff (reset)
        chk_out |-> 32'(mux_sel) == {bits_at(exp_mux, 1), bits_at(exp_mux, 0)})
        else report_mismatch("mux_sel", 32'(mux_sel), {bits_at(exp_mux, 1), bits_at(exp_mux, 0)});

    adc_ok: assert property (@(posedge clk) disable iff (reset)
        chk_out |-> 32'(adc_ctrl) == exp_adc)
        else report_mismatch("adc_ctrl", 32'(adc_ctrl), exp_adc);

    expect_ok: assert property (@(posedge clk) disable iff (reset)
        chk_out |-> halfstrips_expect == exp_expect)
        else report_mismatch("halfstrips_expect", halfstrips_expect, exp_expect);

    rd_count_ok: assert property (@(posedge clk) disable iff (reset)
        chk_count |-> rd_pulses == exp_rd)
        else report_mismatch("serial_rd_n pulses", rd_pulses, exp_rd);

    wr_count_ok: assert property (@(posedge clk) disable iff (reset)
        chk_count |-> wr_pulses == exp_wr)
        else report_mismatch("serial_wr_n pulses", wr_pulses, exp_wr);

    idle_ok: assert property (@(posedge clk) disable iff (reset)
        chk_idle |-> serial_rd_n && serial_wr_n)
        else report_mismatch("serial_rd_n/serial_wr_n", {serial_rd_n, serial_wr_n}, 2'b11);

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial
    begin
        logic [3:0]  adr;
        void'($urandom(45));
        reset       = 1'b1;
        ft_rxf_n    = 1'b1;
        ft_txe_n    = 1'b1;
        ft_byte_out = '0;
        status      = '0;
        chk_read    = 1'b0;
        chk_out     = 1'b0;
        chk_count   = 1'b0;
        chk_idle    = 1'b0;
        bp_on       = 1'b0;
        exp_rd      = 0;
        exp_wr      = 0;
        got_word    = '0;
        exp_word    = '0;
        exp_comp    = '0;
        exp_pulse   = `PULSE_CTRL_RESET;
        exp_mux     = '0;
        exp_expect  = '0;
        exp_adc     = `ADC_RESET;

        repeat (3) @(posedge clk);
        #1;
        reset    = 1'b0;
        chk_idle = 1'b1;
        settle_and_check(1'b0);     // Reset values on every output
        chk_idle = 1'b0;

        randomize_status();
        read_reg(`ADR_PULSE_CTRL);
        read_reg(`ADR_ADC);

        // Decoded registers, then mux and expect words
        for (int n = 0; n < 3; n++)
        begin
            write_reg(`ADR_COMP_CONFIG, $urandom);
            read_reg(`ADR_COMP_CONFIG);
            write_reg(`ADR_PULSE_CTRL, $urandom);
            read_reg(`ADR_PULSE_CTRL);
            write_reg(`ADR_ADC, $urandom);
            read_reg(`ADR_ADC);
        end
        write_reg(`ADR_MUX_SEL, $urandom);
        read_reg(`ADR_MUX_SEL);
        write_reg(`ADR_HALFSTRIPS_EXPECT, $urandom);
        read_reg(`ADR_HALFSTRIPS_EXPECT);

        // Live inputs and unmapped addresses
        randomize_status();
        read_reg(`ADR_HALFSTRIPS);
        read_reg(`ADR_HALFSTRIPS_ERRCNT);
        read_reg(4'h3);
        read_reg(4'hF);

        bp_on = 1'b1;
        for (int n = 0; n < 10; n++)
        begin
            adr = writable_adr($urandom % 5);
            write_reg(adr, $urandom);
            randomize_status();
            read_reg(adr);
        end

        // Unknown command nibble is dropped
        send_byte({`ADR_COMP_CONFIG, 4'h3});
        settle_and_check(1'b0);
        write_reg(`ADR_MUX_SEL, $urandom);
        read_reg(`ADR_MUX_SEL);

        end_run();
    end

endmodule

/* sim.f */
+incdir+src
+incdir+bench
src/serial_pkg.sv
src/ft245_link.sv
src/ctrl_regs.sv
src/readback_mux.sv
src/serial_top.sv
bench/serial_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the serial bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module serial_tb -o serial_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/serial_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
exit 0
